// File: dv/ffcp_tb.sv
// ==================================================
// loopback testbench of the FFCP link
// scenario table, frame dropping on both links,
// delivery checks against a model queue
// ==================================================

`include "ffcp_cfg.svh"

module ffcp_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_rows = 6;
	localparam int frame_bytes = 1 + `FFCP_DATA_LEN;
	localparam int quiet_len = `FFCP_RESEND_TIMEOUT + 100;
	localparam int push_limit = 5000;
	localparam int settle_limit = 20000;
	localparam logic [31:0] lfsr_taps = 32'h8020_0003;

	// payload count, data frame drop mask, ack frame drop mask
	int row_count [num_rows] = '{10, 60, 12, 12, 12, 14};
	logic [31:0] row_dmask_tab [num_rows] = '{32'h0, 32'h0, 32'h0000_0004,
		32'h0, 32'h0000_0010, 32'h0};
	logic [31:0] row_amask_tab [num_rows] = '{32'h0, 32'h0, 32'h0,
		32'h0000_0f80, 32'h0000_0003, 32'h0000_ffff};

	logic clk;
	logic rst;
	logic pkt_valid;
	logic [31:0] pkt_data;
	logic pkt_ready;
	logic dlink_out_valid;
	logic [7:0] dlink_out_byte;
	logic dlink_in_valid;
	logic [7:0] dlink_in_byte;
	logic alink_out_valid;
	logic [7:0] alink_out_byte;
	logic alink_in_valid;
	logic [7:0] alink_in_byte;
	logic deliver_valid;
	logic [`FFCP_INDEX_LEN-1:0] deliver_index;
	logic [31:0] deliver_data;

	logic [31:0] lfsr_state = 32'h9044;
	logic [31:0] exp_q [$];
	logic [31:0] exp_word;
	logic [`FFCP_INDEX_LEN-1:0] exp_index = '0;
	int errors = 0;
	int checks = 0;
	int tests_failed = 0;
	logic timed_out = 1'b0;
	logic pushed_any = 1'b0;
	logic first_meta_seen = 1'b0;
	int quiet_cycles = 0;

	// per-row state of the link monitor
	logic [31:0] row_dmask = '0;
	logic [31:0] row_amask = '0;
	int dlink_pos = 0;
	int dlink_frames = 0;
	int ack_frames = 0;
	logic dlink_drop = 1'b0;
	logic alink_drop = 1'b0;
	logic ack_passed_row = 1'b0;
	logic [2**`FFCP_INDEX_LEN-1:0] seen_idx = '0;
	int distinct_row = 0;
	int first_stall = -1;

	ffcp_link_top dut_i (
		.clk(clk), .rst(rst),
		.pkt_valid(pkt_valid), .pkt_data(pkt_data), .pkt_ready(pkt_ready),
		.dlink_out_valid(dlink_out_valid), .dlink_out_byte(dlink_out_byte),
		.dlink_in_valid(dlink_in_valid), .dlink_in_byte(dlink_in_byte),
		.alink_out_valid(alink_out_valid), .alink_out_byte(alink_out_byte),
		.alink_in_valid(alink_in_valid), .alink_in_byte(alink_in_byte),
		.deliver_valid(deliver_valid), .deliver_index(deliver_index),
		.deliver_data(deliver_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0]) begin
			n = n ^ lfsr_taps;
		end
		return n;
	endfunction

	// one LFSR step per payload bit
	task automatic draw_word(output logic [31:0] word);
		for (int i = 0; i < 32; i++) begin
			word[i] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic note_timeout(input string what);
		$display("timeout at %0t: %s", $time, what);
		errors++;
		timed_out = 1'b1;
	endtask

	task automatic push_payloads(input int count);
		int n;
		int waited;
		logic [31:0] word;
		n = 0;
		waited = 0;
		while (n < count && !timed_out) begin
			@(negedge clk);
			if (pkt_ready) begin
				draw_word(word);
				pkt_valid = 1'b1;
				pkt_data = word;
				exp_q.push_back(word);
				pushed_any = 1'b1;
				n++;
				waited = 0;
			end else begin
				pkt_valid = 1'b0;
				if (first_stall < 0) begin
					first_stall = n;
				end
				waited++;
				if (waited > push_limit) begin
					note_timeout("pkt_ready stayed low, payload entry never resumed");
				end
			end
		end
		@(negedge clk);
		pkt_valid = 1'b0;
	endtask

	task automatic wait_delivered();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && !timed_out) begin
			@(posedge clk);
			waited++;
			if (waited > settle_limit) begin
				note_timeout("pushed payloads were not all delivered");
			end
		end
	endtask

	// quiet for longer than the resend timeout means every ack got through
	task automatic wait_quiet();
		int waited;
		waited = 0;
		while (quiet_cycles < quiet_len && !timed_out) begin
			@(posedge clk);
			waited++;
			if (waited > settle_limit) begin
				note_timeout("the links kept carrying frames after the last delivery");
			end
		end
	endtask

	task automatic run_row(input int r);
		int errs_before;
		@(posedge clk);
		errs_before = errors;
		row_dmask = row_dmask_tab[r];
		row_amask = row_amask_tab[r];
		dlink_frames = 0;
		ack_frames = 0;
		ack_passed_row = 1'b0;
		seen_idx = '0;
		distinct_row = 0;
		first_stall = -1;
		push_payloads(row_count[r]);
		wait_delivered();
		wait_quiet();
		checks++;
		if (distinct_row > `FFCP_WINDOW_LEN) begin
			$display("MISMATCH at %0t: %0d distinct indices sent before any ack, window is %0d",
				$time, distinct_row, `FFCP_WINDOW_LEN);
			errors++;
		end
		// with the first acks lost the head cannot move while payloads go in
		if (&row_amask[`FFCP_WINDOW_LEN-1:0] && row_count[r] > `PB_ALMOST_FULL) begin
			checks++;
			if (first_stall != `PB_ALMOST_FULL) begin
				$display("MISMATCH at %0t: pkt_ready fell after %0d payloads, expected %0d",
					$time, first_stall, `PB_ALMOST_FULL);
				errors++;
			end
		end
		if (errors != errs_before) begin
			tests_failed++;
		end
		$display("test %0d: %0d payloads, %0d data frames, %0d ack frames, %0d errors",
			r, row_count[r], dlink_frames, ack_frames, errors - errs_before);
	endtask

	// loopback with frame dropping, plus the delivery and frame checks
	always @(negedge clk) begin
		if (!pushed_any && (dlink_out_valid || alink_out_valid || deliver_valid)) begin
			$display("a frame or delivery appeared at %0t before any payload was pushed", $time);
			errors++;
		end
		if (dlink_out_valid === 1'b1) begin
			if (dlink_pos == 0) begin
				dlink_drop = (dlink_frames < 32) ? row_dmask[dlink_frames] : 1'b0;
				dlink_frames++;
				if (!first_meta_seen) begin
					first_meta_seen = 1'b1;
					checks++;
					if (dlink_out_byte !== {2'd0, 6'd0}) begin
						$display("MISMATCH at %0t: first data frame metadata %02h, expected syn 0",
							$time, dlink_out_byte);
						errors++;
					end
				end
				if (!ack_passed_row && !seen_idx[dlink_out_byte[5:0]]) begin
					seen_idx[dlink_out_byte[5:0]] = 1'b1;
					distinct_row++;
				end
			end
			dlink_pos = (dlink_pos == frame_bytes - 1) ? 0 : dlink_pos + 1;
		end
		dlink_in_valid = dlink_out_valid && !dlink_drop;
		dlink_in_byte = dlink_out_byte;

		// every byte on the ack link is a whole ack frame
		if (alink_out_valid === 1'b1) begin
			alink_drop = (ack_frames < 32) ? row_amask[ack_frames] : 1'b0;
			ack_frames++;
			if (!alink_drop) begin
				ack_passed_row = 1'b1;
			end
			checks++;
			if (alink_out_byte[7:6] !== 2'd2) begin
				$display("MISMATCH at %0t: ack link byte %02h does not carry type ack",
					$time, alink_out_byte);
				errors++;
			end
		end
		alink_in_valid = alink_out_valid && !alink_drop;
		alink_in_byte = alink_out_byte;

		if (deliver_valid === 1'b1) begin
			checks++;
			if (exp_q.size() == 0) begin
				$display("MISMATCH at %0t: delivery of index %0d with nothing outstanding",
					$time, deliver_index);
				errors++;
			end else begin
				exp_word = exp_q.pop_front();
				if (deliver_data !== exp_word || deliver_index !== exp_index) begin
					$display("MISMATCH at %0t: delivered index %0d data %08h, expected %0d %08h",
						$time, deliver_index, deliver_data, exp_index, exp_word);
					errors++;
				end
				exp_index = exp_index + 1'b1;
			end
		end

		if (dlink_out_valid || alink_out_valid || dlink_in_valid || alink_in_valid
				|| deliver_valid) begin
			quiet_cycles = 0;
		end else begin
			quiet_cycles++;
		end
	end

	initial begin
		rst = 1'b1;
		pkt_valid = 1'b0;
		pkt_data = '0;
		dlink_in_valid = 1'b0;
		dlink_in_byte = '0;
		alink_in_valid = 1'b0;
		alink_in_byte = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		checks++;
		if (pkt_ready !== 1'b1 || dlink_out_valid !== 1'b0 || alink_out_valid !== 1'b0
				|| deliver_valid !== 1'b0) begin
			$display("MISMATCH at %0t: outputs not at their reset values", $time);
			errors++;
		end
		rst = 1'b0;
		// idle stretch, nothing may leave the DUT before the first push
		repeat (20) @(negedge clk);
		for (int r = 0; r < num_rows && !timed_out; r++) begin
			run_row(r);
		end
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			num_rows, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: include/ffcp_cfg.svh
// ==================================================
// FFCP link configuration macros
// window, packet buffer, payload and timeout sizes
// ==================================================

`ifndef FFCP_CFG_SVH
`define FFCP_CFG_SVH

// width of the frame index, indices wrap around at 2**FFCP_INDEX_LEN
`define FFCP_INDEX_LEN 6

// maximum number of unacked frames in flight
`define FFCP_WINDOW_LEN 8

// payload bytes carried by every syn or msg frame
`define FFCP_DATA_LEN 4

// packet buffer depth, has to be a power of two
`define PB_QUEUE_LEN 16
// occupancy at which the buffer stops taking payloads
`define PB_ALMOST_FULL 12

// idle cycles without an ack before rewinding to the window head
`define FFCP_RESEND_TIMEOUT 200
// cycles without any ack before restarting the link with a syn
`define FFCP_RESYN_TIMEOUT 2000

`endif

// File: logic/ffcp_deframer.sv
// ==================================================
// frame parser
// registers the link bytes and splits them into
// type, index and payload word
// ==================================================

`include "ffcp_cfg.svh"

module ffcp_deframer (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        link_valid,
	input  ffcp_pkg::byte_t             link_byte,
	output logic                        meta_valid,
	output ffcp_pkg::ffcp_type_t        meta_type,
	output ffcp_pkg::ffcp_index_t       meta_index,
	output logic                        frame_valid,
	output logic [`FFCP_DATA_LEN*8-1:0] frame_data
);
	import ffcp_pkg::*;

	localparam int w = `FFCP_DATA_LEN * 8;

	logic in_valid_q;
	byte_t in_byte_q;
	logic in_data;
	logic [$clog2(`FFCP_DATA_LEN)-1:0] cnt;
	logic [w-1:0] data_q;
	ffcp_type_t in_type;
	ffcp_index_t in_index;
	ffcp_type_t type_q;
	ffcp_index_t index_q;

	assign in_type = ffcp_type_t'(in_byte_q[7 -: 2]);
	assign in_index = in_byte_q[`FFCP_INDEX_LEN-1:0];

	// metadata fields stay valid until the payload is complete
	assign meta_valid = in_valid_q && !in_data;
	assign meta_type = in_data ? type_q : in_type;
	assign meta_index = in_data ? index_q : in_index;
	assign frame_valid = in_valid_q && in_data && cnt == `FFCP_DATA_LEN - 1;
	assign frame_data = {in_byte_q, data_q[w-1:8]};

	always_ff @(posedge clk) begin
		if (rst) begin
			in_valid_q <= 1'b0;
			in_data <= 1'b0;
			cnt <= '0;
		end else begin
			in_valid_q <= link_valid;
			if (in_valid_q && !in_data) begin
				// an ack has no payload, so stay on metadata
				in_data <= in_type != ffcp_ack;
				cnt <= '0;
			end else if (in_valid_q) begin
				if (cnt == `FFCP_DATA_LEN - 1) begin
					in_data <= 1'b0;
				end
				cnt <= cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		in_byte_q <= link_byte;
		if (meta_valid) begin
			type_q <= in_type;
			index_q <= in_index;
		end
		if (in_valid_q && in_data) begin
			data_q <= {in_byte_q, data_q[w-1:8]};
		end
	end

endmodule

// File: logic/ffcp_framer.sv
// ==================================================
// frame serializer
// one metadata byte, then the payload bytes unless
// the frame is an ack
// ==================================================

`include "ffcp_cfg.svh"

module ffcp_framer (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        issue,
	input  ffcp_pkg::ffcp_type_t        issue_type,
	input  ffcp_pkg::ffcp_index_t       issue_index,
	input  logic [`FFCP_DATA_LEN*8-1:0] payload,
	output logic                        busy,
	output logic                        link_valid,
	output ffcp_pkg::byte_t             link_byte
);
	import ffcp_pkg::*;

	localparam int cnt_w = $clog2(`FFCP_DATA_LEN + 1);

	logic active;
	logic is_ack;
	logic last;
	logic [cnt_w-1:0] cnt;
	logic [`FFCP_DATA_LEN*8-1:0] pay_q;

	assign busy = active;
	// cnt holds the number of payload bytes already on the link
	assign last = is_ack || cnt == `FFCP_DATA_LEN;

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			is_ack <= 1'b0;
			link_valid <= 1'b0;
			cnt <= '0;
		end else if (!active) begin
			if (issue) begin
				active <= 1'b1;
				is_ack <= issue_type == ffcp_ack;
				link_valid <= 1'b1;
				cnt <= '0;
			end
		end else if (last) begin
			active <= 1'b0;
			link_valid <= 1'b0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// byte 0 of the payload goes out first
	always_ff @(posedge clk) begin
		if (!active && issue) begin
			link_byte <= {issue_type, issue_index};
			pay_q <= payload;
		end else if (active && !last) begin
			link_byte <= pay_q[7:0];
			pay_q <= pay_q >> 8;
		end
	end

endmodule

// File: logic/ffcp_link_top.sv
// ==================================================
// FFCP link top level
// transmit end, receive end and the two byte links
// ==================================================

`include "ffcp_cfg.svh"

module ffcp_link_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        pkt_valid,
	input  logic [`FFCP_DATA_LEN*8-1:0] pkt_data,
	output logic                        pkt_ready,
	output logic                        dlink_out_valid,
	output ffcp_pkg::byte_t             dlink_out_byte,
	input  logic                        dlink_in_valid,
	input  ffcp_pkg::byte_t             dlink_in_byte,
	output logic                        alink_out_valid,
	output ffcp_pkg::byte_t             alink_out_byte,
	input  logic                        alink_in_valid,
	input  ffcp_pkg::byte_t             alink_in_byte,
	output logic                        deliver_valid,
	output ffcp_pkg::ffcp_index_t       deliver_index,
	output logic [`FFCP_DATA_LEN*8-1:0] deliver_data
);
	import ffcp_pkg::*;

	pb_ptr_t pb_head;
	pb_ptr_t pb_tail;
	pb_ptr_t issue_pos;
	pb_ptr_t new_head;
	logic head_load;
	logic issue;
	logic data_busy;
	ffcp_type_t issue_type;
	ffcp_index_t issue_index;
	logic [`FFCP_DATA_LEN*8-1:0] rd_data;
	logic ack_valid;
	ffcp_index_t ack_in_index;
	logic frame_valid;
	ffcp_type_t frame_type;
	ffcp_index_t frame_index;
	logic [`FFCP_DATA_LEN*8-1:0] frame_data;
	logic ack_issue;
	logic ack_busy;
	ffcp_index_t ack_out_index;

	ffcp_tx_queue tx_queue_i (
		.clk(clk), .rst(rst),
		.wr_en(pkt_valid), .wr_data(pkt_data),
		.head_load(head_load), .new_head(new_head),
		.rd_pos(issue_pos), .rd_data(rd_data),
		.head(pb_head), .tail(pb_tail), .ready(pkt_ready)
	);

	ffcp_tx_server tx_server_i (
		.clk(clk), .rst(rst),
		.pb_head(pb_head), .pb_tail(pb_tail),
		.ack_valid(ack_valid), .ack_index(ack_in_index),
		.busy(data_busy),
		.issue(issue), .issue_type(issue_type), .issue_index(issue_index),
		.issue_pos(issue_pos), .head_load(head_load), .new_head(new_head)
	);

	ffcp_framer data_framer_i (
		.clk(clk), .rst(rst),
		.issue(issue), .issue_type(issue_type), .issue_index(issue_index),
		.payload(rd_data), .busy(data_busy),
		.link_valid(dlink_out_valid), .link_byte(dlink_out_byte)
	);

	// only ack frames travel on the ack link
	ffcp_deframer ack_deframer_i (
		.clk(clk), .rst(rst),
		.link_valid(alink_in_valid), .link_byte(alink_in_byte),
		.meta_valid(ack_valid), .meta_type(), .meta_index(ack_in_index),
		.frame_valid(), .frame_data()
	);

	ffcp_deframer data_deframer_i (
		.clk(clk), .rst(rst),
		.link_valid(dlink_in_valid), .link_byte(dlink_in_byte),
		.meta_valid(), .meta_type(frame_type), .meta_index(frame_index),
		.frame_valid(frame_valid), .frame_data(frame_data)
	);

	ffcp_rx_server rx_server_i (
		.clk(clk), .rst(rst),
		.frame_valid(frame_valid), .frame_type(frame_type),
		.frame_index(frame_index), .frame_data(frame_data),
		.ack_busy(ack_busy),
		.deliver_valid(deliver_valid), .deliver_index(deliver_index),
		.deliver_data(deliver_data),
		.ack_issue(ack_issue), .ack_index(ack_out_index)
	);

	ffcp_framer ack_framer_i (
		.clk(clk), .rst(rst),
		.issue(ack_issue), .issue_type(ffcp_ack), .issue_index(ack_out_index),
		.payload('0), .busy(ack_busy),
		.link_valid(alink_out_valid), .link_byte(alink_out_byte)
	);

endmodule

// File: logic/ffcp_pkg.sv
// ==================================================
// FFCP shared types
// frame type encoding, frame index, buffer pointer
// and link byte
// ==================================================

`include "ffcp_cfg.svh"

package ffcp_pkg;

	// frame type, sits in bits 7..6 of the metadata byte
	typedef enum logic [1:0] {
		ffcp_syn = 2'd0,
		ffcp_msg = 2'd1,
		ffcp_ack = 2'd2
	} ffcp_type_t;

	// frame index in bits 5..0 of the metadata byte, wraps around
	typedef logic [`FFCP_INDEX_LEN-1:0] ffcp_index_t;

	// position inside the packet buffer
	typedef logic [$clog2(`PB_QUEUE_LEN)-1:0] pb_ptr_t;

	typedef logic [7:0] byte_t;

endpackage

// File: logic/ffcp_rx_server.sv
// ==================================================
// receive server of the FFCP link
// in-order acceptance, payload delivery and
// cumulative ack requests
// ==================================================

`include "ffcp_cfg.svh"

module ffcp_rx_server (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        frame_valid,
	input  ffcp_pkg::ffcp_type_t        frame_type,
	input  ffcp_pkg::ffcp_index_t       frame_index,
	input  logic [`FFCP_DATA_LEN*8-1:0] frame_data,
	input  logic                        ack_busy,
	output logic                        deliver_valid,
	output ffcp_pkg::ffcp_index_t       deliver_index,
	output logic [`FFCP_DATA_LEN*8-1:0] deliver_data,
	output logic                        ack_issue,
	output ffcp_pkg::ffcp_index_t       ack_index
);
	import ffcp_pkg::*;

	ffcp_index_t expected;
	ffcp_index_t behind;
	logic ack_pending;
	logic ack_send;
	logic accept;
	logic dup;
	logic discard;

	// a syn always restarts the sequence, a msg must be the next index
	assign accept = frame_valid && (frame_type == ffcp_syn
		|| (frame_type == ffcp_msg && frame_index == expected));

	// frames already delivered are re-acked so a lost ack gets replaced
	assign behind = expected - frame_index;
	assign dup = frame_valid && frame_type == ffcp_msg
		&& behind != '0 && behind <= `FFCP_WINDOW_LEN;
	assign discard = frame_valid && !accept;

	assign ack_send = ack_pending && !ack_busy && !ack_issue;

	always_ff @(posedge clk) begin
		if (rst) begin
			expected <= '0;
			deliver_valid <= 1'b0;
			ack_pending <= 1'b0;
			ack_issue <= 1'b0;
		end else begin
			deliver_valid <= accept;
			ack_issue <= ack_send;
			if (accept) begin
				expected <= (frame_type == ffcp_syn) ? ffcp_index_t'(1) : expected + 1'b1;
			end
			if (ack_send) begin
				ack_pending <= 1'b0;
			end
			if (accept || dup) begin
				ack_pending <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			deliver_index <= frame_index;
			deliver_data <= frame_data;
		end
		// the ack carries the next index the receiver wants
		if (ack_send) begin
			ack_index <= expected;
		end
	end

	// frames arrive at least a full frame apart on the data link
	a_no_overlap: assert property (@(posedge clk) disable iff (rst)
		deliver_valid |-> !discard);

endmodule

// File: logic/ffcp_tx_queue.sv
// ==================================================
// packet buffer of the transmit end
// payload storage, head and tail pointers, ready flag
// ==================================================

`include "ffcp_cfg.svh"

module ffcp_tx_queue (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         wr_en,
	input  logic [`FFCP_DATA_LEN*8-1:0]  wr_data,
	input  logic                         head_load,
	input  ffcp_pkg::pb_ptr_t            new_head,
	input  ffcp_pkg::pb_ptr_t            rd_pos,
	output logic [`FFCP_DATA_LEN*8-1:0]  rd_data,
	output ffcp_pkg::pb_ptr_t            head,
	output ffcp_pkg::pb_ptr_t            tail,
	output logic                         ready
);
	import ffcp_pkg::*;

	logic [`FFCP_DATA_LEN*8-1:0] mem [`PB_QUEUE_LEN];
	pb_ptr_t fill;
	logic wr_fire;

	// entries between head and tail are waiting for an ack
	assign fill = tail - head;
	assign ready = fill < `PB_ALMOST_FULL;
	assign wr_fire = wr_en && ready;
	assign rd_data = mem[rd_pos];

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			mem[tail] <= wr_data;
		end
	end

	// the head only moves by a load from an accepted ack
	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
		end else begin
			if (head_load) begin
				head <= new_head;
			end
			if (wr_fire) begin
				tail <= tail + 1'b1;
			end
		end
	end

	// the user offers a payload only while the buffer is ready
	a_no_write_full: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> ready);

	// acks from the receive end only release entries that were written
	a_head_in_range: assert property (@(posedge clk) disable iff (rst)
		head_load |-> pb_ptr_t'(new_head - head) <= fill);

endmodule

// File: logic/ffcp_tx_server.sv
// ==================================================
// transmit server of the FFCP link
// sliding window, resend and resync timers,
// frame issue requests to the data framer
// ==================================================

`include "ffcp_cfg.svh"

module ffcp_tx_server (
	input  logic                  clk,
	input  logic                  rst,
	input  ffcp_pkg::pb_ptr_t     pb_head,
	input  ffcp_pkg::pb_ptr_t     pb_tail,
	input  logic                  ack_valid,
	input  ffcp_pkg::ffcp_index_t ack_index,
	input  logic                  busy,
	output logic                  issue,
	output ffcp_pkg::ffcp_type_t  issue_type,
	output ffcp_pkg::ffcp_index_t issue_index,
	output ffcp_pkg::pb_ptr_t     issue_pos,
	output logic                  head_load,
	output ffcp_pkg::pb_ptr_t     new_head
);
	import ffcp_pkg::*;

	localparam int resend_w = $clog2(`FFCP_RESEND_TIMEOUT + 1);
	localparam int resync_w = $clog2(`FFCP_RESYN_TIMEOUT + 1);

	ffcp_index_t win_head;
	ffcp_index_t curr_index;
	ffcp_index_t outstanding;
	ffcp_index_t ack_offset;
	pb_ptr_t pending;
	logic syn_flag;
	logic ack_accept;
	logic resend_fire;
	logic resync_fire;
	logic [resend_w-1:0] resend_cnt;
	logic [resync_w-1:0] resync_cnt;

	// win_head maps onto pb_head, so every index has a fixed buffer slot
	assign outstanding = curr_index - win_head;
	assign pending = pb_tail - pb_head;
	assign ack_offset = ack_index - win_head;

	// wraparound distance keeps stale and far-ahead acks out
	assign ack_accept = ack_valid && ack_offset <= `FFCP_WINDOW_LEN
		&& ack_offset <= ffcp_index_t'(pending);

	assign issue = !busy && outstanding < `FFCP_WINDOW_LEN
		&& outstanding < ffcp_index_t'(pending);
	assign issue_type = (syn_flag && curr_index == '0) ? ffcp_syn : ffcp_msg;
	assign issue_index = curr_index;
	assign issue_pos = pb_ptr_t'(outstanding) + pb_head;

	assign head_load = ack_accept;
	assign new_head = pb_ptr_t'(ack_offset) + pb_head;

	assign resend_fire = !ack_accept && resend_cnt == `FFCP_RESEND_TIMEOUT - 1;
	assign resync_fire = !ack_accept && resync_cnt == `FFCP_RESYN_TIMEOUT - 1;

	always_ff @(posedge clk) begin
		if (rst || resync_fire) begin
			win_head <= '0;
			curr_index <= '0;
			syn_flag <= 1'b1;
		end else begin
			if (ack_accept) begin
				win_head <= ack_index;
				syn_flag <= 1'b0;
			end
			// an ack past the current index means those frames got through
			if (ack_accept && ack_offset > outstanding) begin
				curr_index <= ack_index;
			end else if (issue) begin
				curr_index <= curr_index + 1'b1;
			end else if (resend_fire) begin
				curr_index <= win_head;
			end
		end
	end

	// resend timer runs only while frames are in flight
	always_ff @(posedge clk) begin
		if (rst || resync_fire || resend_fire || ack_accept || outstanding == '0) begin
			resend_cnt <= '0;
		end else begin
			resend_cnt <= resend_cnt + 1'b1;
		end
	end

	// rewinds do not restart this one, only an ack or an empty buffer does
	always_ff @(posedge clk) begin
		if (rst || resync_fire || ack_accept || pending == '0) begin
			resync_cnt <= '0;
		end else begin
			resync_cnt <= resync_cnt + 1'b1;
		end
	end

	// the framer takes every issue and reports busy right after it
	a_issue_taken: assert property (@(posedge clk) disable iff (rst)
		issue |=> busy);

endmodule

// File: sources.f
+incdir+include
logic/ffcp_pkg.sv
logic/ffcp_tx_queue.sv
logic/ffcp_tx_server.sv
logic/ffcp_framer.sv
logic/ffcp_deframer.sv
logic/ffcp_rx_server.sv
logic/ffcp_link_top.sv
dv/ffcp_tb.sv
